// ==== logic/bridge_params.svh ====
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// bus and line geometry
`define BRIDGE_ADDR_W      32
`define BRIDGE_WORD_W      32
`define BRIDGE_STRB_W      (`BRIDGE_WORD_W / 8)
`define BRIDGE_LINE_WORDS  4

// fixed axi encodings
`define BRIDGE_INST_ID     4'd0
`define BRIDGE_DATA_ID     4'd1
`define BRIDGE_LINE_LEN    8'd3
`define BRIDGE_WORD_SIZE   3'd2

`endif

// ==== logic/axi_pkg.sv ====
package axi_pkg;

    // burst length minus one
    typedef logic [7:0] axi_len_t;

    // log2 of bytes per beat
    typedef logic [2:0] axi_size_t;

    // transaction id of the instruction or data side
    typedef logic [3:0] axi_id_t;

endpackage

// ==== logic/bridge_pkg.sv ====
`include "bridge_params.svh"

package bridge_pkg;

    typedef enum logic [1:0] {
        inst_read,
        data_read,
        data_write
    } req_kind_t;

    typedef enum logic [2:0] {
        idle,
        read_addr,
        read_data,
        write_addr,
        write_data,
        write_resp,
        done
    } bridge_state_t;

    typedef logic [`BRIDGE_LINE_WORDS*`BRIDGE_WORD_W-1:0] line_t;

    // word slot inside a line
    typedef logic [$clog2(`BRIDGE_LINE_WORDS)-1:0] beat_idx_t;

endpackage

// ==== logic/bridge_fsm.sv ====
`include "bridge_params.svh"

module bridge_fsm (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      inst_rd_req,
    input  logic                      inst_rd_type,
    input  logic [`BRIDGE_ADDR_W-1:0] inst_rd_addr,
    input  logic                      data_rd_req,
    input  logic                      data_rd_type,
    input  logic [`BRIDGE_ADDR_W-1:0] data_rd_addr,
    input  axi_pkg::axi_size_t        data_rd_size,
    input  logic                      data_wr_req,
    input  logic                      data_wr_type,
    input  logic [`BRIDGE_ADDR_W-1:0] data_wr_addr,
    input  axi_pkg::axi_size_t        data_wr_size,
    output logic                      inst_rd_rdy,
    output logic                      data_rd_rdy,
    output logic                      data_wr_rdy,
    output axi_pkg::axi_id_t          arid,
    output logic [`BRIDGE_ADDR_W-1:0] araddr,
    output axi_pkg::axi_len_t         arlen,
    output axi_pkg::axi_size_t        arsize,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic                      rvalid,
    input  logic                      rlast,
    output logic                      rready,
    output logic [`BRIDGE_ADDR_W-1:0] awaddr,
    output axi_pkg::axi_len_t         awlen,
    output axi_pkg::axi_size_t        awsize,
    output logic                      awvalid,
    input  logic                      awready,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready,
    input  logic                      last_beat,
    output logic                      beat_clear,
    output logic                      beat_step,
    output logic                      capture,
    output logic                      rd_capture,
    output logic                      line_clear,
    output logic                      ret_pulse,
    output bridge_pkg::req_kind_t     ret_kind,
    output logic                      data_wr_ok
);
    import axi_pkg::*;
    import bridge_pkg::*;

    bridge_state_t             state;
    bridge_state_t             state_next;
    req_kind_t                 kind_q;
    logic [`BRIDGE_ADDR_W-1:0] addr_q;
    axi_len_t                  len_q;
    axi_size_t                 size_q;
    logic                      accept;

    // data write wins over data read, which wins over instruction read
    assign data_wr_rdy = (state == idle) && data_wr_req;
    assign data_rd_rdy = (state == idle) && data_rd_req && !data_wr_req;
    assign inst_rd_rdy = (state == idle) && inst_rd_req && !data_wr_req && !data_rd_req;
    assign accept      = data_wr_rdy || data_rd_rdy || inst_rd_rdy;

    always_ff @(posedge aclk) begin
        if (rst) begin
            state      <= idle;
            kind_q     <= inst_read;
            data_wr_ok <= 1'b0;
        end else begin
            state      <= state_next;
            data_wr_ok <= bready && bvalid;
            if (data_wr_rdy) begin
                kind_q <= data_write;
            end else if (data_rd_rdy) begin
                kind_q <= data_read;
            end else if (inst_rd_rdy) begin
                kind_q <= inst_read;
            end
        end
    end

    // request fields held for the whole transaction
    always_ff @(posedge aclk) begin
        if (data_wr_rdy) begin
            addr_q <= data_wr_addr;
            len_q  <= data_wr_type ? `BRIDGE_LINE_LEN : '0;
            size_q <= data_wr_type ? `BRIDGE_WORD_SIZE : data_wr_size;
        end else if (data_rd_rdy) begin
            addr_q <= data_rd_addr;
            len_q  <= data_rd_type ? `BRIDGE_LINE_LEN : '0;
            size_q <= data_rd_type ? `BRIDGE_WORD_SIZE : data_rd_size;
        end else if (inst_rd_rdy) begin
            addr_q <= inst_rd_addr;
            len_q  <= inst_rd_type ? `BRIDGE_LINE_LEN : '0;
            size_q <= `BRIDGE_WORD_SIZE;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (data_wr_rdy) begin
                    state_next = write_addr;
                end else if (accept) begin
                    state_next = read_addr;
                end
            end
            read_addr: begin
                if (arready) begin
                    state_next = read_data;
                end
            end
            read_data: begin
                if (rvalid && rlast) begin
                    state_next = done;
                end
            end
            write_addr: begin
                if (awready) begin
                    state_next = write_data;
                end
            end
            write_data: begin
                if (wready && last_beat) begin
                    state_next = write_resp;
                end
            end
            write_resp: begin
                if (bvalid) begin
                    state_next = done;
                end
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    assign arvalid = (state == read_addr);
    assign rready  = (state == read_data);
    assign awvalid = (state == write_addr);
    assign wvalid  = (state == write_data);
    assign bready  = (state == write_resp);

    assign arid   = (kind_q == inst_read) ? `BRIDGE_INST_ID : `BRIDGE_DATA_ID;
    assign araddr = addr_q;
    assign arlen  = len_q;
    assign arsize = size_q;
    assign awaddr = addr_q;
    assign awlen  = len_q;
    assign awsize = size_q;

    // steering for the counter and the data path
    assign beat_clear = accept;
    assign capture    = data_wr_rdy;
    assign line_clear = data_rd_rdy || inst_rd_rdy;
    assign rd_capture = rready && rvalid;
    assign beat_step  = rd_capture || (wvalid && wready);
    assign ret_pulse  = rd_capture && rlast;
    assign ret_kind   = kind_q;

endmodule

// ==== logic/beat_counter.sv ====
module beat_counter (
    input  logic                  aclk,
    input  logic                  rst,
    input  logic                  beat_clear,
    input  logic                  beat_step,
    input  axi_pkg::axi_len_t     last_len,
    output bridge_pkg::beat_idx_t beat_idx,
    output logic                  last_beat
);
    import axi_pkg::*;
    import bridge_pkg::*;

    beat_idx_t count;

    always_ff @(posedge aclk) begin
        if (rst) begin
            count <= '0;
        end else if (beat_clear) begin
            count <= '0;
        end else if (beat_step) begin
            count <= count + 1'b1;
        end
    end

    assign beat_idx = count;

    // zero-length bursts are last on their only beat
    assign last_beat = (axi_len_t'(count) == last_len);

endmodule

// ==== logic/read_line_assembler.sv ====
`include "bridge_params.svh"

module read_line_assembler (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      rd_capture,
    input  logic                      line_clear,
    input  logic                      ret_pulse,
    input  bridge_pkg::req_kind_t     ret_kind,
    input  bridge_pkg::beat_idx_t     beat_idx,
    input  logic [`BRIDGE_WORD_W-1:0] rdata,
    output logic                      inst_ret_valid,
    output logic                      data_ret_valid,
    output bridge_pkg::line_t         inst_ret_data,
    output bridge_pkg::line_t         data_ret_data
);
    import bridge_pkg::*;

    line_t line_q;

    // word reads leave the upper slots at zero
    always_ff @(posedge aclk) begin
        if (line_clear) begin
            line_q <= '0;
        end else if (rd_capture) begin
            line_q[beat_idx*`BRIDGE_WORD_W +: `BRIDGE_WORD_W] <= rdata;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            inst_ret_valid <= 1'b0;
            data_ret_valid <= 1'b0;
        end else begin
            inst_ret_valid <= ret_pulse && (ret_kind == inst_read);
            data_ret_valid <= ret_pulse && (ret_kind == data_read);
        end
    end

    // one line buffer serves both requesters
    assign inst_ret_data = line_q;
    assign data_ret_data = line_q;

endmodule

// ==== logic/write_line_serializer.sv ====
`include "bridge_params.svh"

module write_line_serializer (
    input  logic                      aclk,
    input  logic                      rst,
    input  logic                      capture,
    input  logic                      data_wr_type,
    input  logic [`BRIDGE_STRB_W-1:0] data_wr_wstrb,
    input  bridge_pkg::line_t         data_wr_data,
    input  bridge_pkg::beat_idx_t     beat_idx,
    output logic [`BRIDGE_WORD_W-1:0] wdata,
    output logic [`BRIDGE_STRB_W-1:0] wstrb
);
    import bridge_pkg::*;

    line_t                     line_q;
    logic [`BRIDGE_STRB_W-1:0] strb_q;

    always_ff @(posedge aclk) begin
        if (capture) begin
            line_q <= data_wr_data;
        end
    end

    // line writes always carry full words
    always_ff @(posedge aclk) begin
        if (rst) begin
            strb_q <= '0;
        end else if (capture) begin
            strb_q <= data_wr_type ? {`BRIDGE_STRB_W{1'b1}} : data_wr_wstrb;
        end
    end

    assign wdata = line_q[beat_idx*`BRIDGE_WORD_W +: `BRIDGE_WORD_W];
    assign wstrb = strb_q;

endmodule

// ==== logic/cache_axi_bridge.sv ====
`include "bridge_params.svh"

module cache_axi_bridge (
    input  logic                      aclk,
    input  logic                      rst,

    // instruction cache read
    input  logic                      inst_rd_req,
    input  logic                      inst_rd_type,
    input  logic [`BRIDGE_ADDR_W-1:0] inst_rd_addr,
    output logic                      inst_rd_rdy,
    output logic                      inst_ret_valid,
    output bridge_pkg::line_t         inst_ret_data,

    // data cache read
    input  logic                      data_rd_req,
    input  logic                      data_rd_type,
    input  logic [`BRIDGE_ADDR_W-1:0] data_rd_addr,
    input  axi_pkg::axi_size_t        data_rd_size,
    output logic                      data_rd_rdy,
    output logic                      data_ret_valid,
    output bridge_pkg::line_t         data_ret_data,

    // data cache write
    input  logic                      data_wr_req,
    input  logic                      data_wr_type,
    input  logic [`BRIDGE_ADDR_W-1:0] data_wr_addr,
    input  axi_pkg::axi_size_t        data_wr_size,
    input  logic [`BRIDGE_STRB_W-1:0] data_wr_wstrb,
    input  bridge_pkg::line_t         data_wr_data,
    output logic                      data_wr_rdy,
    output logic                      data_wr_ok,

    // axi read
    output axi_pkg::axi_id_t          arid,
    output logic [`BRIDGE_ADDR_W-1:0] araddr,
    output axi_pkg::axi_len_t         arlen,
    output axi_pkg::axi_size_t        arsize,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [`BRIDGE_WORD_W-1:0] rdata,
    input  logic                      rlast,
    input  logic                      rvalid,
    output logic                      rready,

    // axi write
    output logic [`BRIDGE_ADDR_W-1:0] awaddr,
    output axi_pkg::axi_len_t         awlen,
    output axi_pkg::axi_size_t        awsize,
    output logic                      awvalid,
    input  logic                      awready,
    output logic [`BRIDGE_WORD_W-1:0] wdata,
    output logic [`BRIDGE_STRB_W-1:0] wstrb,
    output logic                      wlast,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready
);
    import bridge_pkg::*;

    logic      beat_clear;
    logic      beat_step;
    logic      capture;
    logic      rd_capture;
    logic      line_clear;
    logic      ret_pulse;
    req_kind_t ret_kind;
    beat_idx_t beat_idx;

    bridge_fsm u_fsm (
        .aclk         (aclk         ),
        .rst          (rst          ),
        .inst_rd_req  (inst_rd_req  ),
        .inst_rd_type (inst_rd_type ),
        .inst_rd_addr (inst_rd_addr ),
        .data_rd_req  (data_rd_req  ),
        .data_rd_type (data_rd_type ),
        .data_rd_addr (data_rd_addr ),
        .data_rd_size (data_rd_size ),
        .data_wr_req  (data_wr_req  ),
        .data_wr_type (data_wr_type ),
        .data_wr_addr (data_wr_addr ),
        .data_wr_size (data_wr_size ),
        .inst_rd_rdy  (inst_rd_rdy  ),
        .data_rd_rdy  (data_rd_rdy  ),
        .data_wr_rdy  (data_wr_rdy  ),
        .arid         (arid         ),
        .araddr       (araddr       ),
        .arlen        (arlen        ),
        .arsize       (arsize       ),
        .arvalid      (arvalid      ),
        .arready      (arready      ),
        .rvalid       (rvalid       ),
        .rlast        (rlast        ),
        .rready       (rready       ),
        .awaddr       (awaddr       ),
        .awlen        (awlen        ),
        .awsize       (awsize       ),
        .awvalid      (awvalid      ),
        .awready      (awready      ),
        .wvalid       (wvalid       ),
        .wready       (wready       ),
        .bvalid       (bvalid       ),
        .bready       (bready       ),
        .last_beat    (wlast        ),
        .beat_clear   (beat_clear   ),
        .beat_step    (beat_step    ),
        .capture      (capture      ),
        .rd_capture   (rd_capture   ),
        .line_clear   (line_clear   ),
        .ret_pulse    (ret_pulse    ),
        .ret_kind     (ret_kind     ),
        .data_wr_ok   (data_wr_ok   )
    );

    // last beat of the burst doubles as wlast
    beat_counter u_beat_counter (
        .aclk       (aclk      ),
        .rst        (rst       ),
        .beat_clear (beat_clear),
        .beat_step  (beat_step ),
        .last_len   (awlen     ),
        .beat_idx   (beat_idx  ),
        .last_beat  (wlast     )
    );

    read_line_assembler u_read_line (
        .aclk           (aclk          ),
        .rst            (rst           ),
        .rd_capture     (rd_capture    ),
        .line_clear     (line_clear    ),
        .ret_pulse      (ret_pulse     ),
        .ret_kind       (ret_kind      ),
        .beat_idx       (beat_idx      ),
        .rdata          (rdata         ),
        .inst_ret_valid (inst_ret_valid),
        .data_ret_valid (data_ret_valid),
        .inst_ret_data  (inst_ret_data ),
        .data_ret_data  (data_ret_data )
    );

    write_line_serializer u_write_line (
        .aclk          (aclk         ),
        .rst           (rst          ),
        .capture       (capture      ),
        .data_wr_type  (data_wr_type ),
        .data_wr_wstrb (data_wr_wstrb),
        .data_wr_data  (data_wr_data ),
        .beat_idx      (beat_idx     ),
        .wdata         (wdata        ),
        .wstrb         (wstrb        )
    );

endmodule

// ==== testbench/axi_slave_model.sv ====
module axi_slave_model (
    input  logic        aclk,
    input  logic        rst,
    input  logic        ar_stall,
    input  logic        r_stall,
    input  logic        aw_stall,
    input  logic        w_stall,
    input  logic        b_stall,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    input  logic        bready
);
    logic [31:0] mem [0:63];
    logic        rd_busy;
    logic [5:0]  rd_idx;
    logic [7:0]  rd_len;
    logic [7:0]  rd_beat;
    logic [1:0]  wr_phase;
    logic [5:0]  wr_idx;

    // fill pattern follows the byte address of each word
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = ((32'h1000 + 32'(i) * 32'd4) * 32'h9e3779b1) ^ 32'h5a5a_0000;
        end
    end

    assign arready = !rd_busy && !ar_stall;
    assign rvalid  = rd_busy && !r_stall;
    assign rdata   = mem[rd_idx + rd_beat[5:0]];
    assign rlast   = (rd_beat == rd_len);
    assign awready = (wr_phase == 2'd0) && !aw_stall;
    assign wready  = (wr_phase == 2'd1) && !w_stall;
    assign bvalid  = (wr_phase == 2'd2) && !b_stall;

    always @(posedge aclk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            rd_beat  <= '0;
            wr_phase <= 2'd0;
        end else begin
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_idx  <= araddr[7:2];
                rd_len  <= arlen;
                rd_beat <= '0;
            end else if (rvalid && rready) begin
                rd_beat <= rd_beat + 8'd1;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_idx   <= awaddr[7:2];
                wr_phase <= 2'd1;
            end else if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        mem[wr_idx][b*8 +: 8] <= wdata[b*8 +: 8];
                    end
                end
                wr_idx <= wr_idx + 6'd1;
                if (wlast) begin
                    wr_phase <= 2'd2;
                end
            end else if (bvalid && bready) begin
                wr_phase <= 2'd0;
            end
        end
    end

endmodule

// ==== testbench/tb_cache_axi_bridge.sv ====
module tb_cache_axi_bridge;
    import axi_pkg::*;
    import bridge_pkg::*;

    localparam int timeout_cycles = 400;
    localparam logic [31:0] base_addr = 32'h0000_1000;

    logic aclk, rst;
    logic inst_rd_req, inst_rd_type, inst_rd_rdy, inst_ret_valid;
    logic [31:0] inst_rd_addr;
    line_t inst_ret_data;
    logic data_rd_req, data_rd_type, data_rd_rdy, data_ret_valid;
    logic [31:0] data_rd_addr;
    axi_size_t data_rd_size;
    line_t data_ret_data;
    logic data_wr_req, data_wr_type, data_wr_rdy, data_wr_ok;
    logic [31:0] data_wr_addr;
    axi_size_t data_wr_size;
    logic [3:0] data_wr_wstrb;
    line_t data_wr_data;
    axi_id_t arid;
    logic [31:0] araddr, awaddr, rdata, wdata;
    axi_len_t arlen, awlen;
    axi_size_t arsize, awsize;
    logic arvalid, arready, rlast, rvalid, rready, awvalid, awready;
    logic [3:0] wstrb;
    logic wlast, wvalid, wready, bvalid, bready;
    logic [4:0] stall;

    logic [31:0] lfsr;
    logic [31:0] stall_lfsr;
    logic [31:0] shadow [0:63];
    logic [46:0] ar_q [$];
    logic [42:0] aw_q [$];
    logic [36:0] w_q [$];
    int errors, checks, inst_pulses, data_pulses, ok_pulses;
    int exp_inst, exp_data, exp_ok;

    cache_axi_bridge UUT (.*);

    axi_slave_model slave (.*, .ar_stall(stall[0]), .r_stall(stall[1]),
        .aw_stall(stall[2]), .w_stall(stall[3]), .b_stall(stall[4]));

    always #10 aclk = ~aclk;

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    always @(posedge aclk) begin
        #2;
        for (int i = 0; i < 5; i++) begin
            stall_lfsr = lfsr_step(stall_lfsr);
            stall[i] = stall_lfsr[0];
        end
    end

    // bus monitor
    always @(posedge aclk) begin
        if (arvalid && arready) ar_q.push_back({arid, araddr, arlen, arsize});
        if (awvalid && awready) aw_q.push_back({awaddr, awlen, awsize});
        if (wvalid && wready) w_q.push_back({wdata, wstrb, wlast});
        if (inst_ret_valid) inst_pulses++;
        if (data_ret_valid) data_pulses++;
        if (data_wr_ok) ok_pulses++;
    end

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout while waiting for %s", what);
        $display("Test FAILED");
        $finish;
    endtask

    function automatic line_t expected_line(input logic [5:0] idx, input logic line);
        line_t l;
        l = '0;
        for (int k = 0; k < (line ? 4 : 1); k++) begin
            l[k*32 +: 32] = shadow[idx + 6'(k)];
        end
        return l;
    endfunction

    task automatic check_ar(input axi_id_t id, input logic [5:0] idx, input logic line,
                            input axi_size_t size);
        logic [46:0] a;
        if (ar_q.size() == 0) begin
            errors++;
            $display("no ar handshake was seen for a read");
        end else begin
            a = ar_q.pop_front();
            check("arid", 128'(a[46:43]), 128'(id));
            check("araddr", 128'(a[42:11]), 128'(base_addr + {24'd0, idx, 2'b00}));
            check("arlen", 128'(a[10:3]), line ? 128'd3 : 128'd0);
            check("arsize", 128'(a[2:0]), line ? 128'd2 : 128'(size));
        end
    endtask

    task automatic read_check(input logic is_inst, input logic line, input logic [5:0] idx,
                              input axi_size_t size);
        int n;
        line_t exp;
        exp = expected_line(idx, line);
        if (is_inst) begin
            inst_rd_req = 1'b1;
            inst_rd_type = line;
            inst_rd_addr = base_addr + {24'd0, idx, 2'b00};
        end else begin
            data_rd_req = 1'b1;
            data_rd_type = line;
            data_rd_addr = base_addr + {24'd0, idx, 2'b00};
            data_rd_size = size;
        end
        for (n = 0; n < timeout_cycles; n++) begin
            @(posedge aclk);
            if (is_inst ? inst_rd_rdy : data_rd_rdy) break;
        end
        if (n == timeout_cycles) abort_run("read request acceptance");
        #2;
        inst_rd_req = 1'b0;
        data_rd_req = 1'b0;
        for (n = 0; n < timeout_cycles; n++) begin
            @(posedge aclk);
            if (is_inst ? inst_ret_valid : data_ret_valid) break;
        end
        if (n == timeout_cycles) abort_run("read data return");
        if (is_inst) begin
            exp_inst++;
            check("inst_ret_data", inst_ret_data, exp);
        end else begin
            exp_data++;
            check("data_ret_data", data_ret_data, exp);
        end
        check_ar(is_inst ? 4'd0 : 4'd1, idx, line, is_inst ? 3'd2 : size);
        #2;
    endtask

    task automatic write_check(input logic line, input logic [5:0] idx, input axi_size_t size,
                               input logic [3:0] strb, input line_t data);
        int n;
        logic [42:0] a;
        logic [36:0] w;
        data_wr_req = 1'b1;
        data_wr_type = line;
        data_wr_addr = base_addr + {24'd0, idx, 2'b00};
        data_wr_size = size;
        data_wr_wstrb = strb;
        data_wr_data = data;
        for (n = 0; n < timeout_cycles; n++) begin
            @(posedge aclk);
            if (data_wr_rdy) break;
        end
        if (n == timeout_cycles) abort_run("write request acceptance");
        #2;
        data_wr_req = 1'b0;
        for (n = 0; n < timeout_cycles; n++) begin
            @(posedge aclk);
            if (data_wr_ok) break;
        end
        if (n == timeout_cycles) abort_run("write completion");
        exp_ok++;
        a = aw_q.pop_front();
        check("awaddr", 128'(a[42:11]), 128'(base_addr + {24'd0, idx, 2'b00}));
        check("awlen", 128'(a[10:3]), line ? 128'd3 : 128'd0);
        check("awsize", 128'(a[2:0]), line ? 128'd2 : 128'(size));
        check("w beat count", 128'(w_q.size()), line ? 128'd4 : 128'd1);
        for (int k = 0; k < (line ? 4 : 1); k++) begin
            w = w_q.pop_front();
            check("wdata", 128'(w[36:5]), 128'(data[k*32 +: 32]));
            check("wstrb", 128'(w[4:1]), line ? 128'hf : 128'(strb));
            check("wlast", 128'(w[0]), 128'(k == (line ? 3 : 0)));
            for (int b = 0; b < 4; b++) begin
                if (line || strb[b]) shadow[idx + 6'(k)][b*8 +: 8] = data[k*32 + b*8 +: 8];
            end
        end
        #2;
    endtask

    // write, data read and instruction read raised in the same cycle
    task automatic arbitration_test();
        int n;
        int order [$];
        logic [2:0] seen;
        logic [2:0] acc;
        logic [42:0] a;
        logic [36:0] w;
        line_t exp_d;
        line_t exp_i;
        logic [31:0] v;
        draw(32, v);
        exp_d = expected_line(6'd5, 1'b0);
        exp_i = expected_line(6'd16, 1'b1);
        data_wr_req = 1'b1;
        data_wr_type = 1'b0;
        data_wr_addr = base_addr + 32'd200;
        data_wr_size = 3'd2;
        data_wr_wstrb = 4'hf;
        data_wr_data = {96'd0, v};
        data_rd_req = 1'b1;
        data_rd_type = 1'b0;
        data_rd_addr = base_addr + 32'd20;
        data_rd_size = 3'd2;
        inst_rd_req = 1'b1;
        inst_rd_type = 1'b1;
        inst_rd_addr = base_addr + 32'd64;
        seen = '0;
        for (n = 0; n < timeout_cycles * 3 && seen != 3'b111; n++) begin
            @(posedge aclk);
            acc = {data_wr_rdy, data_rd_rdy, inst_rd_rdy};
            if (acc[2]) order.push_back(2);
            if (acc[1]) order.push_back(1);
            if (acc[0]) order.push_back(0);
            if (data_wr_ok) seen[2] = 1'b1;
            if (data_ret_valid) begin
                seen[1] = 1'b1;
                check("data_ret_data", data_ret_data, exp_d);
            end
            if (inst_ret_valid) begin
                seen[0] = 1'b1;
                check("inst_ret_data", inst_ret_data, exp_i);
            end
            #2;
            if (acc[2]) data_wr_req = 1'b0;
            if (acc[1]) data_rd_req = 1'b0;
            if (acc[0]) inst_rd_req = 1'b0;
        end
        if (seen != 3'b111) abort_run("completion of the arbitrated requests");
        shadow[50] = v;
        exp_ok++;
        exp_data++;
        exp_inst++;
        check("acceptance count", 128'(order.size()), 128'd3);
        for (int k = 0; k < order.size() && k < 3; k++) begin
            check("acceptance order", 128'(order[k]), 128'(2 - k));
        end
        a = aw_q.pop_front();
        check("awaddr", 128'(a[42:11]), 128'(base_addr + 32'd200));
        w = w_q.pop_front();
        check("wdata", 128'(w[36:5]), 128'(v));
        check_ar(4'd1, 6'd5, 1'b0, 3'd2);
        check_ar(4'd0, 6'd16, 1'b1, 3'd2);
    endtask

    initial begin
        logic [31:0] v;
        logic [31:0] r;
        line_t d;
        aclk = 1'b0;
        rst = 1'b1;
        {inst_rd_req, inst_rd_type, inst_rd_addr} = '0;
        {data_rd_req, data_rd_type, data_rd_addr, data_rd_size} = '0;
        {data_wr_req, data_wr_type, data_wr_addr, data_wr_size} = '0;
        data_wr_wstrb = '0;
        data_wr_data = '0;
        stall = '0;
        lfsr = 32'h29ce;
        stall_lfsr = 32'h29ce;
        for (int i = 0; i < 64; i++) begin
            shadow[i] = ((base_addr + 32'(i) * 32'd4) * 32'h9e3779b1) ^ 32'h5a5a_0000;
        end
        repeat (8) @(posedge aclk);
        #2;
        rst = 1'b0;
        check("arvalid", 128'(arvalid), 128'd0);
        check("awvalid", 128'(awvalid), 128'd0);
        check("wvalid", 128'(wvalid), 128'd0);
        check("rready", 128'(rready), 128'd0);
        check("bready", 128'(bready), 128'd0);
        check("inst_ret_valid", 128'(inst_ret_valid), 128'd0);
        check("data_ret_valid", 128'(data_ret_valid), 128'd0);
        check("data_wr_ok", 128'(data_wr_ok), 128'd0);
        arbitration_test();
        for (int t = 0; t < 40; t++) begin
            draw(6, r);
            for (int k = 0; k < 4; k++) begin
                draw(32, v);
                d[k*32 +: 32] = v;
            end
            draw(2, v);
            case (v[1:0])
                2'd0: read_check(1'b1, r[0], r[0] ? {r[5:2], 2'b00} : r[5:0], 3'd2);
                2'd1: read_check(1'b0, r[0], r[0] ? {r[5:2], 2'b00} : r[5:0], 3'(r[1:0] % 3));
                default: begin
                    draw(4, v);
                    if (r[0]) begin
                        write_check(1'b1, {r[5:2], 2'b00}, 3'd2, 4'hf, d);
                        read_check(1'b0, 1'b1, {r[5:2], 2'b00}, 3'd2);
                    end else begin
                        write_check(1'b0, r[5:0], 3'd2, v[3:0], d);
                        read_check(1'b0, 1'b0, r[5:0], 3'd2);
                    end
                end
            endcase
        end
        repeat (4) @(posedge aclk);
        check("inst_ret_valid pulses", 128'(inst_pulses), 128'(exp_inst));
        check("data_ret_valid pulses", 128'(data_pulses), 128'(exp_data));
        check("data_wr_ok pulses", 128'(ok_pulses), 128'(exp_ok));
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/axi_pkg.sv
logic/bridge_pkg.sv
logic/bridge_fsm.sv
logic/beat_counter.sv
logic/read_line_assembler.sv
logic/write_line_serializer.sv
logic/cache_axi_bridge.sv
testbench/axi_slave_model.sv
testbench/tb_cache_axi_bridge.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_cache_axi_bridge
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
